/* src/mixer_pkg.sv */
// ====================
// audio side definitions for the matrix mixer
// sample and coefficient formats, channel counts, saturation limits
// ====================
`default_nettype none

package mixer_pkg;

	// ====================
	// sample format
	localparam int sample_width = 24;
	typedef logic signed [sample_width-1:0] sample_t;

	// clip limits, full scale either way
	localparam sample_t sample_max = {1'b0, {(sample_width-1){1'b1}}};
	localparam sample_t sample_min = {1'b1, {(sample_width-1){1'b0}}};

	// ====================
	// coefficients, signed 4.12 fixed point
	localparam int coeff_width = 16;
	typedef logic signed [coeff_width-1:0] coeff_t;
	localparam int coeff_frac = 12;
	localparam coeff_t coeff_unity = 16'h1000;   // 1.0

	// channel counts, cut down from the six-way board mixer
	localparam int num_inputs  = 2;   // alpha, beta
	localparam int num_outputs = 2;   // dac alpha, dac beta

	// intermediate widths of the mix datapath
	localparam int prod_width   = sample_width + coeff_width;   // one sample times coeff
	localparam int sum_width    = prod_width + 1;               // two products added
	localparam int scaled_width = sum_width + coeff_width;      // after the output gain

endpackage

`default_nettype wire

/* src/mixer_ctrl_pkg.sv */
// ====================
// control side definitions for the matrix mixer
// sequencer states, output ids, command word layout, bus width
// ====================
`default_nettype none

package mixer_ctrl_pkg;

	// frame sequencer states
	typedef enum logic [1:0] {
		s_idle,
		s_select,
		s_frame_out,
		s_cleanup
	} seq_state_t;

	// output ids, same width as the command output field
	typedef enum logic [3:0] {
		dac_alpha = 4'd0,
		dac_beta  = 4'd1
	} output_id_t;

	localparam int wb_width = 32;

	// ====================
	// command word fields
	localparam int cmd_out_msb = 31;   // output address
	localparam int cmd_out_lsb = 28;
	localparam int cmd_in_msb  = 27;   // input address
	localparam int cmd_in_lsb  = 24;
	localparam int cmd_val_msb = 23;   // signed value
	localparam int cmd_val_lsb = 8;

	localparam logic [3:0] gain_addr = 4'hF;   // input addr of the output gain
	localparam int frame_cycles = 5;           // busy window after frame accept

endpackage

`default_nettype wire

/* src/coeff_cmd_slave.sv */
// ====================
// wishbone classic slave taking coefficient command words
// one register, no address lines; acks are held off during a frame
// ====================
`default_nettype none

module coeff_cmd_slave (
	input  logic                                 CLOCK_50,
	input  logic                                 rst,
	input  logic                                 wb_cyc,
	input  logic                                 wb_stb,
	input  logic                                 wb_we,
	input  logic [mixer_ctrl_pkg::wb_width-1:0]  wb_dat_i,
	output logic [mixer_ctrl_pkg::wb_width-1:0]  wb_dat_o,
	output logic                                 wb_ack,
	input  logic                                 frame_busy,
	output logic                                 cmd_write,
	output logic [3:0]                           cmd_out_addr,
	output logic [3:0]                           cmd_in_addr,
	output mixer_pkg::coeff_t                    cmd_value
);
	import mixer_ctrl_pkg::*;

	logic [wb_width-1:0] last_cmd;   // readback copy
	logic                req_ok;

	// live request, not in the ack cycle, sequencer not busy
	assign req_ok = wb_cyc && wb_stb && !wb_ack && !frame_busy;

	// bank takes the write on the same edge the ack rises
	assign cmd_write    = req_ok && wb_we;
	assign cmd_out_addr = wb_dat_i[cmd_out_msb:cmd_out_lsb];
	assign cmd_in_addr  = wb_dat_i[cmd_in_msb:cmd_in_lsb];
	assign cmd_value    = wb_dat_i[cmd_val_msb:cmd_val_lsb];
	assign wb_dat_o     = last_cmd;

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			wb_ack   <= 1'b0;
			last_cmd <= '0;
		end
		else
		begin
			wb_ack <= req_ok;   // single cycle pulse
			if (cmd_write)
				last_cmd <= wb_dat_i;   // kept even if the address is bad
		end
	end

	// ====================
	ack_single: assert property (@(posedge CLOCK_50) disable iff (rst) wb_ack |=> !wb_ack);
	// no ack may start while the sequencer holds a frame
	ack_not_busy: assert property (@(posedge CLOCK_50) disable iff (rst)
		$rose(wb_ack) |-> !$past(frame_busy));

endmodule

`default_nettype wire

/* src/coeff_bank.sv */
// ====================
// coefficient store, one input set and one gain per output
// resets to straight routing, read out for the selected output
// ====================
`default_nettype none

module coeff_bank (
	input  logic                       CLOCK_50,
	input  logic                       rst,
	input  logic                       cmd_write,
	input  logic [3:0]                 cmd_out_addr,
	input  logic [3:0]                 cmd_in_addr,
	input  mixer_pkg::coeff_t          cmd_value,
	input  mixer_ctrl_pkg::output_id_t config_id,
	output mixer_pkg::coeff_t          coeff_alpha,
	output mixer_pkg::coeff_t          coeff_beta,
	output mixer_pkg::coeff_t          gain
);
	import mixer_pkg::*;
	import mixer_ctrl_pkg::*;

	coeff_t coef_q [num_outputs][num_inputs];   // [output][input]
	coeff_t gain_q [num_outputs];

	logic                           out_ok;
	logic                           in_ok;
	logic                           is_gain;
	logic [$clog2(num_outputs)-1:0] wr_out;
	logic [$clog2(num_inputs)-1:0]  wr_in;
	logic [$clog2(num_outputs)-1:0] rd_out;

	// address checks, bad commands change nothing
	assign is_gain = (cmd_in_addr == gain_addr);
	assign out_ok  = int'(cmd_out_addr) < num_outputs;
	assign in_ok   = int'(cmd_in_addr) < num_inputs;
	assign wr_out  = cmd_out_addr[$clog2(num_outputs)-1:0];
	assign wr_in   = cmd_in_addr[$clog2(num_inputs)-1:0];

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			for (int o = 0; o < num_outputs; o++)
			begin
				gain_q[o] <= coeff_unity;
				for (int i = 0; i < num_inputs; i++)
					coef_q[o][i] <= (o == i) ? coeff_unity : '0;   // own input only
			end
		end
		else if (cmd_write && out_ok)
		begin
			if (is_gain)
				gain_q[wr_out] <= cmd_value;
			else if (in_ok)
				coef_q[wr_out][wr_in] <= cmd_value;
		end
	end

	// read side, input 0 is alpha, input 1 is beta
	assign rd_out      = config_id[$clog2(num_outputs)-1:0];
	assign coeff_alpha = coef_q[rd_out][0];
	assign coeff_beta  = coef_q[rd_out][1];
	assign gain        = gain_q[rd_out];

	// sequencer must only ever select an existing output
	cfg_valid: assert property (@(posedge CLOCK_50) disable iff (rst)
		int'(config_id) < num_outputs);

endmodule

`default_nettype wire

/* src/mix_channel.sv */
// ====================
// one stereo side of the mixer, combinational
// weighted sum of alpha and beta, output gain, saturate to 24 bits
// ====================
`default_nettype none

module mix_channel (
	input  mixer_pkg::sample_t sample_alpha,
	input  mixer_pkg::sample_t sample_beta,
	input  mixer_pkg::coeff_t  coeff_alpha,
	input  mixer_pkg::coeff_t  coeff_beta,
	input  mixer_pkg::coeff_t  gain,
	output mixer_pkg::sample_t result,
	output logic               clip
);
	import mixer_pkg::*;

	logic signed [prod_width-1:0]   prod_alpha;
	logic signed [prod_width-1:0]   prod_beta;
	logic signed [sum_width-1:0]    sum_full;
	logic signed [sum_width-1:0]    sum_scaled;
	logic signed [scaled_width-1:0] gained;
	logic signed [scaled_width-1:0] gained_scaled;

	always_comb
	begin
		// ====================
		// input weighting
		prod_alpha = prod_width'(sample_alpha) * prod_width'(coeff_alpha);
		prod_beta  = prod_width'(sample_beta) * prod_width'(coeff_beta);
		sum_full   = sum_width'(prod_alpha) + sum_width'(prod_beta);   // no overflow here
		sum_scaled = sum_full >>> coeff_frac;   // back to sample scale

		// output gain, same 4.12 format
		gained        = scaled_width'(sum_scaled) * scaled_width'(gain);
		gained_scaled = gained >>> coeff_frac;

		// ====================
		// saturation
		if (gained_scaled > scaled_width'(sample_max))
		begin
			result = sample_max;
			clip   = 1'b1;
		end
		else if (gained_scaled < scaled_width'(sample_min))
		begin
			result = sample_min;
			clip   = 1'b1;
		end
		else
		begin
			result = gained_scaled[sample_width-1:0];   // fits, plain truncate
			clip   = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/frame_sequencer.sv */
// ====================
// frame sequencer: capture one stereo frame from both inputs,
// then select and write out each output in turn, alpha first
// ====================
`default_nettype none

module frame_sequencer (
	input  logic                       CLOCK_50,
	input  logic                       rst,
	input  logic                       frame_valid,
	input  mixer_pkg::sample_t         in_alpha_left,
	input  mixer_pkg::sample_t         in_alpha_right,
	input  mixer_pkg::sample_t         in_beta_left,
	input  mixer_pkg::sample_t         in_beta_right,
	output mixer_pkg::sample_t         cap_alpha_left,
	output mixer_pkg::sample_t         cap_alpha_right,
	output mixer_pkg::sample_t         cap_beta_left,
	output mixer_pkg::sample_t         cap_beta_right,
	output mixer_ctrl_pkg::output_id_t config_id,
	input  mixer_pkg::sample_t         mix_left,
	input  mixer_pkg::sample_t         mix_right,
	input  logic                       clip_left_mix,
	input  logic                       clip_right_mix,
	output mixer_pkg::sample_t         dac_alpha_left,
	output mixer_pkg::sample_t         dac_alpha_right,
	output mixer_pkg::sample_t         dac_beta_left,
	output mixer_pkg::sample_t         dac_beta_right,
	output logic                       out_valid,
	output logic [1:0]                 clip,
	output logic                       frame_busy
);
	import mixer_pkg::*;
	import mixer_ctrl_pkg::*;

	seq_state_t                     state;
	logic [$clog2(num_outputs)-1:0] out_cnt;    // next output to select
	logic [1:0]                     clip_acc;   // {right, left} over the frame
	logic                           take;

	assign take = (state == s_idle) && frame_valid;

	// busy also covers the capture cycle, so no command lands on that edge
	assign frame_busy = (state != s_idle) || frame_valid;

	// ====================
	// frame capture, payload only
	always_ff @(posedge CLOCK_50)
	begin
		if (take)
		begin
			cap_alpha_left  <= in_alpha_left;
			cap_alpha_right <= in_alpha_right;
			cap_beta_left   <= in_beta_left;
			cap_beta_right  <= in_beta_right;
		end
	end

	// ====================
	// sequencing
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			state           <= s_idle;
			out_cnt         <= '0;
			config_id       <= dac_alpha;
			clip_acc        <= '0;
			clip            <= '0;
			out_valid       <= 1'b0;
			dac_alpha_left  <= '0;
			dac_alpha_right <= '0;
			dac_beta_left   <= '0;
			dac_beta_right  <= '0;
		end
		else
		begin
			out_valid <= 1'b0;   // pulse
			case (state)
				s_idle:
				begin
					if (take)
					begin
						clip_acc <= '0;
						state    <= s_select;
					end
				end
				s_select:
				begin
					config_id <= output_id_t'(out_cnt);   // bank follows combinationally
					out_cnt   <= out_cnt + 1'b1;
					state     <= s_frame_out;
				end
				s_frame_out:
				begin
					clip_acc <= clip_acc | {clip_right_mix, clip_left_mix};
					if (config_id == dac_alpha)
					begin
						dac_alpha_left  <= mix_left;
						dac_alpha_right <= mix_right;
						state           <= s_select;
					end
					else
					begin
						// last output, frame done
						dac_beta_left  <= mix_left;
						dac_beta_right <= mix_right;
						clip           <= clip_acc | {clip_right_mix, clip_left_mix};
						out_valid      <= 1'b1;
						state          <= s_cleanup;
					end
				end
				s_cleanup:
				begin
					out_cnt <= '0;
					state   <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// out_valid only right after the beta frame-out
	valid_after_last: assert property (@(posedge CLOCK_50) disable iff (rst)
		out_valid |-> $past(state) == s_frame_out && $past(config_id) == dac_beta);

endmodule

`default_nettype wire

/* src/audio_matrix_mixer.sv */
// ====================
// 2x2 stereo audio matrix mixer, top level
// wishbone command slave, coefficient bank, sequencer, two mix channels
// ====================
`default_nettype none

module audio_matrix_mixer (
	input  logic                                CLOCK_50,
	input  logic                                rst,
	input  logic                                wb_cyc,
	input  logic                                wb_stb,
	input  logic                                wb_we,
	input  logic [mixer_ctrl_pkg::wb_width-1:0] wb_dat_i,
	output logic [mixer_ctrl_pkg::wb_width-1:0] wb_dat_o,
	output logic                                wb_ack,
	input  logic                                frame_valid,
	input  mixer_pkg::sample_t                  in_alpha_left,
	input  mixer_pkg::sample_t                  in_alpha_right,
	input  mixer_pkg::sample_t                  in_beta_left,
	input  mixer_pkg::sample_t                  in_beta_right,
	output mixer_pkg::sample_t                  dac_alpha_left,
	output mixer_pkg::sample_t                  dac_alpha_right,
	output mixer_pkg::sample_t                  dac_beta_left,
	output mixer_pkg::sample_t                  dac_beta_right,
	output logic                                out_valid,
	output logic [1:0]                          clip
);
	import mixer_pkg::*;
	import mixer_ctrl_pkg::*;

	// ====================
	// command path
	logic       frame_busy;
	logic       cmd_write;
	logic [3:0] cmd_out_addr;
	logic [3:0] cmd_in_addr;
	coeff_t     cmd_value;

	// coefficient readout for the selected output
	output_id_t config_id;
	coeff_t     coeff_alpha, coeff_beta, gain;

	// captured frame and mix results
	sample_t cap_alpha_left, cap_alpha_right, cap_beta_left, cap_beta_right;
	sample_t mix_left, mix_right;
	logic    clip_left_mix, clip_right_mix;

	coeff_cmd_slave i_coeff_cmd_slave (
		.CLOCK_50, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_dat_i, .wb_dat_o, .wb_ack,
		.frame_busy, .cmd_write, .cmd_out_addr, .cmd_in_addr, .cmd_value
	);

	coeff_bank i_coeff_bank (
		.CLOCK_50, .rst, .cmd_write, .cmd_out_addr, .cmd_in_addr, .cmd_value,
		.config_id, .coeff_alpha, .coeff_beta, .gain
	);

	frame_sequencer i_frame_sequencer (
		.CLOCK_50, .rst, .frame_valid,
		.in_alpha_left, .in_alpha_right, .in_beta_left, .in_beta_right,
		.cap_alpha_left, .cap_alpha_right, .cap_beta_left, .cap_beta_right,
		.config_id, .mix_left, .mix_right, .clip_left_mix, .clip_right_mix,
		.dac_alpha_left, .dac_alpha_right, .dac_beta_left, .dac_beta_right,
		.out_valid, .clip, .frame_busy
	);

	// left and right share the same coefficient set
	mix_channel i_mix_left (
		.sample_alpha(cap_alpha_left), .sample_beta(cap_beta_left),
		.coeff_alpha, .coeff_beta, .gain, .result(mix_left), .clip(clip_left_mix)
	);

	mix_channel i_mix_right (
		.sample_alpha(cap_alpha_right), .sample_beta(cap_beta_right),
		.coeff_alpha, .coeff_beta, .gain, .result(mix_right), .clip(clip_right_mix)
	);

endmodule

`default_nettype wire

/* include/mixer_model.svh */
// ====================
// reference model of the mixer, included inside the testbench module
// reset_model at start, apply_command per acked write, track_frame_edge every
// clock edge to track frame acceptance, predict_frame for the expected outputs
// ====================
`ifndef MIXER_MODEL_SVH
`define MIXER_MODEL_SVH

mixer_pkg::coeff_t mdl_coef [mixer_pkg::num_outputs][mixer_pkg::num_inputs];
mixer_pkg::coeff_t mdl_gain [mixer_pkg::num_outputs];
int                mdl_busy_cnt;   // edges left in the busy window

// straight routing, unity gain
task automatic reset_model();
	for (int o = 0; o < mixer_pkg::num_outputs; o++)
	begin
		mdl_gain[o] = mixer_pkg::coeff_unity;
		for (int i = 0; i < mixer_pkg::num_inputs; i++)
			mdl_coef[o][i] = (o == i) ? mixer_pkg::coeff_unity : '0;
	end
	mdl_busy_cnt = 0;
endtask

// applies one acked command word, bad addresses are dropped
task automatic apply_command(input logic [mixer_ctrl_pkg::wb_width-1:0] word);
	int                o_addr;
	int                i_addr;
	mixer_pkg::coeff_t val;
	o_addr = word[mixer_ctrl_pkg::cmd_out_msb:mixer_ctrl_pkg::cmd_out_lsb];
	i_addr = word[mixer_ctrl_pkg::cmd_in_msb:mixer_ctrl_pkg::cmd_in_lsb];
	val    = word[mixer_ctrl_pkg::cmd_val_msb:mixer_ctrl_pkg::cmd_val_lsb];
	if (o_addr < mixer_pkg::num_outputs)
	begin
		if (i_addr == int'(mixer_ctrl_pkg::gain_addr))
			mdl_gain[o_addr] = val;
		else if (i_addr < mixer_pkg::num_inputs)
			mdl_coef[o_addr][i_addr] = val;
	end
endtask

// call once per edge with the sampled frame_valid
task automatic track_frame_edge(input bit fv, output bit accepted);
	accepted = 1'b0;
	if (mdl_busy_cnt != 0)
		mdl_busy_cnt--;
	else if (fv)
	begin
		accepted     = 1'b1;
		mdl_busy_cnt = mixer_ctrl_pkg::frame_cycles;
	end
endtask

// one side of one output, same fixed point steps as the RTL
function automatic mixer_pkg::sample_t mix_side(input mixer_pkg::sample_t a,
	input mixer_pkg::sample_t b, input int o, output bit clipped);
	longint acc;
	acc = longint'(a) * longint'(mdl_coef[o][0]) + longint'(b) * longint'(mdl_coef[o][1]);
	acc = acc >>> mixer_pkg::coeff_frac;
	acc = (acc * longint'(mdl_gain[o])) >>> mixer_pkg::coeff_frac;
	clipped = 1'b1;
	if (acc > longint'(mixer_pkg::sample_max))
		return mixer_pkg::sample_max;
	if (acc < longint'(mixer_pkg::sample_min))
		return mixer_pkg::sample_min;
	clipped = 1'b0;
	return mixer_pkg::sample_t'(acc);
endfunction

// expected dac values and clip bits for one captured frame
task automatic predict_frame(input mixer_pkg::sample_t al, ar, bl, br,
	output mixer_pkg::sample_t dal, dar, dbl, dbr, output logic [1:0] clip);
	bit c0, c1, c2, c3;
	dal  = mix_side(al, bl, 0, c0);
	dar  = mix_side(ar, br, 0, c1);
	dbl  = mix_side(al, bl, 1, c2);
	dbr  = mix_side(ar, br, 1, c3);
	clip = {c1 | c3, c0 | c2};   // left in bit 0
endtask

`endif

/* dv/tb_audio_matrix_mixer.sv */
// ====================
// testbench for the 2x2 stereo matrix mixer
// random frames and coefficient writes, checked against the included model
// ====================
`default_nettype none

module tb_audio_matrix_mixer;
	import mixer_pkg::*;
	import mixer_ctrl_pkg::*;

	`include "mixer_model.svh"

	localparam int period   = 20;
	localparam int op_count = 80;   // frames plus bus transfers over all tests
	localparam int wait_max = 40;   // handshake timeout, cycles

	logic                CLOCK_50, rst;
	logic                wb_cyc, wb_stb, wb_we, wb_ack;
	logic [wb_width-1:0] wb_dat_i, wb_dat_o;
	logic                frame_valid, out_valid;
	logic [1:0]          clip;
	sample_t             in_alpha_left, in_alpha_right, in_beta_left, in_beta_right;
	sample_t             dac_alpha_left, dac_alpha_right, dac_beta_left, dac_beta_right;

	// expected frames, one entry per accepted frame_valid
	sample_t    q_al [$];
	sample_t    q_ar [$];
	sample_t    q_bl [$];
	sample_t    q_br [$];
	logic [1:0] q_clip [$];
	int         q_cyc [$];

	int cycle, last_cap, accepted_cnt, valid_cnt;
	int errors, test_base, tests_ok, tests_bad;

	audio_matrix_mixer i_audio_matrix_mixer (.*);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #(period / 2) CLOCK_50 = ~CLOCK_50;
	end

	// ====================
	// model follows the frame path on the edges the DUT samples
	always @(posedge CLOCK_50)
	begin
		bit         acc;
		sample_t    dal, dar, dbl, dbr;
		logic [1:0] dclip;
		cycle++;
		if (!rst)
		begin
			track_frame_edge(frame_valid, acc);
			if (acc)
			begin
				predict_frame(in_alpha_left, in_alpha_right, in_beta_left, in_beta_right,
					dal, dar, dbl, dbr, dclip);   // coefficients as of capture
				q_al.push_back(dal);
				q_ar.push_back(dar);
				q_bl.push_back(dbl);
				q_br.push_back(dbr);
				q_clip.push_back(dclip);
				q_cyc.push_back(cycle);
				last_cap = cycle;
				accepted_cnt++;
			end
		end
	end

	// output side, sampled mid cycle
	always @(negedge CLOCK_50)
	begin
		if (!rst && out_valid)
		begin
			valid_cnt++;
			if (q_cyc.size() == 0)
			begin
				$display("out_valid at %0t without an accepted frame", $time);
				errors++;
			end
			else
			begin
				check_value("out_valid latency", 4, cycle - q_cyc.pop_front());
				check_value("dac_alpha_left", q_al.pop_front(), dac_alpha_left);
				check_value("dac_alpha_right", q_ar.pop_front(), dac_alpha_right);
				check_value("dac_beta_left", q_bl.pop_front(), dac_beta_left);
				check_value("dac_beta_right", q_br.pop_front(), dac_beta_right);
				check_value("clip", q_clip.pop_front(), clip);
			end
		end
	end

	task automatic check_value(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED at %0t: %s expected %0d, actual %0d",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	function automatic logic [wb_width-1:0] make_cmd(input int o, input int i,
		input coeff_t v);
		logic [7:0] pad;
		pad = 8'($urandom);   // low byte is not part of the command
		return {o[3:0], i[3:0], v, pad};
	endfunction

	function automatic coeff_t random_coeff(input int span);
		return coeff_t'(int'($urandom_range(2 * span)) - span);
	endfunction

	// ====================
	// bus master, caller sits after a negedge or a posedge
	task automatic wait_ack(output bit seen);
		seen = 1'b0;
		for (int n = 0; n < wait_max && !seen; n++)
		begin
			@(negedge CLOCK_50);
			seen = wb_ack;
		end
	endtask

	task automatic write_command(input logic [wb_width-1:0] word, output int ack_cyc);
		bit seen;
		@(posedge CLOCK_50);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= 1'b1;
		wb_dat_i <= word;
		wait_ack(seen);   // held unchanged while busy
		ack_cyc = cycle;
		if (seen)
			apply_command(word);   // bank took it on the ack edge
		else
		begin
			$display("write of %h was never acknowledged", word);
			errors++;
		end
		@(posedge CLOCK_50);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic read_back(output logic [wb_width-1:0] data);
		bit seen;
		@(posedge CLOCK_50);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= 1'b0;
		wait_ack(seen);
		data = wb_dat_o;
		if (!seen)
		begin
			$display("read was never acknowledged");
			errors++;
		end
		@(posedge CLOCK_50);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	// one cycle strobe, ends on the capture edge
	task automatic send_frame(input sample_t al, ar, bl, br);
		@(posedge CLOCK_50);
		frame_valid    <= 1'b1;
		in_alpha_left  <= al;
		in_alpha_right <= ar;
		in_beta_left   <= bl;
		in_beta_right  <= br;
		@(posedge CLOCK_50);
		frame_valid <= 1'b0;
	endtask

	task automatic random_frame(output sample_t al, ar, bl, br);
		al = sample_t'($urandom);
		ar = sample_t'($urandom);
		bl = sample_t'($urandom);
		br = sample_t'($urandom);
		send_frame(al, ar, bl, br);
	endtask

	task automatic wait_idle();
		bit idle;
		idle = 1'b0;
		for (int n = 0; n < wait_max && !idle; n++)
		begin
			@(negedge CLOCK_50);
			idle = (q_cyc.size() == 0) && (mdl_busy_cnt == 0);
		end
		if (!idle)
		begin
			$display("frames still pending after %0d cycles", wait_max);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == test_base)
		begin
			tests_ok++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - test_base);
		end
		test_base = errors;
	endtask

	// ====================
	// test sequence
	initial
	begin
		sample_t             al, ar, bl, br;
		sample_t             dal, dar, dbl, dbr;
		logic [1:0]          dclip;
		logic [wb_width-1:0] word, rdata;
		int                  ack_cyc, acc_base, ov_base;
		void'($urandom(82));
		rst            = 1'b1;
		wb_cyc         = 1'b0;
		wb_stb         = 1'b0;
		wb_we          = 1'b0;
		wb_dat_i       = '0;
		frame_valid    = 1'b0;
		in_alpha_left  = '0;
		in_alpha_right = '0;
		in_beta_left   = '0;
		in_beta_right  = '0;
		reset_model();
		repeat (3) @(posedge CLOCK_50);
		rst <= 1'b0;

		// straight routing out of reset
		for (int k = 0; k < 6; k++)
		begin
			random_frame(al, ar, bl, br);
			wait_idle();
			check_value("dac_alpha_left", al, dac_alpha_left);
			check_value("dac_alpha_right", ar, dac_alpha_right);
			check_value("dac_beta_left", bl, dac_beta_left);
			check_value("dac_beta_right", br, dac_beta_right);
			check_value("clip", 0, clip);
		end
		finish_test("reset routing");

		for (int k = 0; k < 6; k++)
		begin
			word = make_cmd($urandom_range(1), (k % 3 == 2) ? int'(gain_addr) :
				$urandom_range(1), random_coeff(16'h0800));   // small values
			write_command(word, ack_cyc);
			repeat (2)
			begin
				random_frame(al, ar, bl, br);
				wait_idle();
			end
		end
		finish_test("random coefficients");

		// ====================
		// full scale in, gains of 4 and 8
		write_command(make_cmd(0, 0, coeff_unity), ack_cyc);
		write_command(make_cmd(0, 1, coeff_unity), ack_cyc);
		write_command(make_cmd(0, gain_addr, 16'h4000), ack_cyc);
		write_command(make_cmd(1, 0, 16'h7FFF), ack_cyc);
		write_command(make_cmd(1, 1, 16'h7FFF), ack_cyc);
		write_command(make_cmd(1, gain_addr, 16'h7FFF), ack_cyc);
		send_frame(sample_max, sample_max, sample_max, sample_max);
		wait_idle();
		check_value("dac_alpha_left", sample_max, dac_alpha_left);
		check_value("dac_beta_right", sample_max, dac_beta_right);
		check_value("clip", 2'b11, clip);
		send_frame(sample_min, sample_min, sample_min, sample_min);
		wait_idle();
		check_value("dac_alpha_right", sample_min, dac_alpha_right);
		check_value("dac_beta_left", sample_min, dac_beta_left);
		repeat (2)
		begin
			random_frame(al, ar, bl, br);
			wait_idle();
		end
		finish_test("saturation");

		// write lands in the cycle after capture, must wait for the frame
		word = make_cmd(0, 1, random_coeff(16'h0800));
		fork
			random_frame(al, ar, bl, br);
			begin
				@(posedge CLOCK_50);
				write_command(word, ack_cyc);
			end
		join
		check_value("ack after frame end", 1, ack_cyc >= last_cap + frame_cycles);
		wait_idle();
		random_frame(al, ar, bl, br);   // new coefficient in use here
		wait_idle();
		finish_test("back-pressure");

		acc_base = accepted_cnt;
		ov_base  = valid_cnt;
		for (int k = 0; k < 30; k++)
		begin
			random_frame(al, ar, bl, br);
			repeat ($urandom_range(6)) @(posedge CLOCK_50);   // often inside busy
		end
		wait_idle();
		check_value("out_valid count", accepted_cnt - acc_base, valid_cnt - ov_base);
		finish_test("ignored frames");

		// ====================
		// readback, then bad addresses must not move the outputs
		word = make_cmd(1, 0, random_coeff(16'h0800));
		write_command(word, ack_cyc);
		read_back(rdata);
		check_value("wb_dat_o", word, rdata);
		random_frame(al, ar, bl, br);
		wait_idle();
		// expected result of this frame with the coefficients as they stand now
		predict_frame(al, ar, bl, br, dal, dar, dbl, dbr, dclip);
		for (int k = 0; k < 4; k++)
		begin
			word = (k % 2) ? make_cmd(0, 2 + $urandom_range(12), random_coeff(16'h7000))
				: make_cmd(2 + $urandom_range(13), 0, random_coeff(16'h7000));
			write_command(word, ack_cyc);
		end
		read_back(rdata);
		check_value("wb_dat_o", word, rdata);
		send_frame(al, ar, bl, br);
		wait_idle();
		check_value("dac_alpha_left", dal, dac_alpha_left);
		check_value("dac_alpha_right", dar, dac_alpha_right);
		check_value("dac_beta_left", dbl, dac_beta_left);
		check_value("dac_beta_right", dbr, dac_beta_right);
		check_value("clip", dclip, clip);
		finish_test("readback and bad addresses");

		$display("tests passed %0d, failed %0d", tests_ok, tests_bad);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog, about 20 cycles per operation plus some slack
	initial
	begin
		#(op_count * 20 * period + 100 * period);
		$display("run timed out, the tests did not reach the end");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
src/mixer_pkg.sv
src/mixer_ctrl_pkg.sv
src/coeff_cmd_slave.sv
src/coeff_bank.sv
src/mix_channel.sv
src/frame_sequencer.sv
src/audio_matrix_mixer.sv
dv/tb_audio_matrix_mixer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the mixer testbench with verilator, runs it, checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module tb_audio_matrix_mixer -o sim_mixer

./obj_dir/sim_mixer | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
